// ==== common/pcie_cfg_macros.svh ====
// Register map offsets, magic values and auto-clear defaults shared by the RTL and testbench
`ifndef PCIE_CFG_MACROS_SVH
`define PCIE_CFG_MACROS_SVH

// ----------------------------------------
// Magic words and map size
// ----------------------------------------
`define PCIE_CFG_RW_MAGIC       16'h6745    // Read-write space +0
`define PCIE_CFG_RO_MAGIC       16'h2301    // Read-only space +0
`define PCIE_CFG_MAP_BYTES      16          // Bytes in each space

// ----------------------------------------
// Read-write byte offsets
// ----------------------------------------
`define PCIE_CFG_RW_CTRL        2           // Start bits and auto-clear enables
`define PCIE_CFG_RW_DI          4           // Mgmt write data
`define PCIE_CFG_RW_ADDR        8           // dwaddr, write flags, byte_en
`define PCIE_CFG_RW_TIMER       12          // Auto-clear interval

// ----------------------------------------
// Read-only byte offsets
// ----------------------------------------
`define PCIE_CFG_RO_SPECIAL     2           // Live mgmt enables
`define PCIE_CFG_RO_ID          4           // Bus, device, function
`define PCIE_CFG_RO_COMMAND     6
`define PCIE_CFG_RO_STATUS      8
`define PCIE_CFG_RO_RDINFO      10          // Last access addr, valid, byte_en
`define PCIE_CFG_RO_RDDATA      12          // Last access data

// ----------------------------------------
// Auto-clear defaults
// ----------------------------------------
`define PCIE_CFG_TIMER_DEFAULT  32'd62500   // 1 ms at 62.5 MHz
`define PCIE_CFG_AUTO_CMD_DI    16'h0406    // Command register bits to set
`define PCIE_CFG_AUTO_STATUS_DI 16'hff00    // Write-one-to-clear status bits
`define PCIE_CFG_AUTO_DWADDR    10'd1       // Command/status dword

`endif

// ==== common/pcie_cfg_pkg.sv ====
// Packed struct types for the config-control block, imported by the RTL and the testbench
package pcie_cfg_pkg;

    // Decoded host command, value and mask already in register order
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;          // Bit 15 selects read-write space
        logic [15:0] value;
        logic [15:0] mask;
    } cfg_cmd_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;          // Byte-swapped register bits
    } cfg_rsp_t;

    // Outputs to the core's config-management port
    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic [3:0]  byte_en;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
    } mgmt_req_t;

    typedef struct packed {
        logic [31:0] do_data;       // Read data from the core
        logic        rd_wr_done;
    } mgmt_rsp_t;

    typedef struct packed {
        logic [7:0]  bus;
        logic [4:0]  device;
        logic [2:0]  func;
        logic [15:0] command;
        logic [15:0] status;
    } pcie_status_t;

    typedef struct packed {
        logic start_rd;
        logic start_wr;
        logic status_cl_en;
        logic command_en;
    } rw_ctrl_t;

    // Last completed mgmt access
    typedef struct packed {
        logic        valid;
        logic [9:0]  addr;
        logic [3:0]  byte_en;
        logic [31:0] data;
    } cfgrd_result_t;

endpackage

// ==== src/cfg_cmd_port.sv ====
// Host command port that splits 64-bit command words and returns registered read responses
`timescale 1ns/10ps

module cfg_cmd_port
    import pcie_cfg_pkg::*;
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  logic [63:0] i_cmd_data,
    output cfg_cmd_t    o_cmd,
    input  logic [15:0] i_rd_data,         // Window from the regfile
    output logic        o_rsp_valid,
    output cfg_rsp_t    o_rsp
);

    // ----------------------------------------
    // Command decode
    // ----------------------------------------
    always_comb
    begin
        o_cmd.rd    = i_cmd_valid & i_cmd_data[12];
        o_cmd.wr    = i_cmd_valid & i_cmd_data[13];
        o_cmd.addr  = i_cmd_data[31:16];
        o_cmd.mask  = {i_cmd_data[39:32], i_cmd_data[47:40]};    // First byte to upper half
        o_cmd.value = {i_cmd_data[55:48], i_cmd_data[63:56]};
    end

    // ----------------------------------------
    // Response
    // ----------------------------------------
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            o_rsp_valid <= 1'b0;
        end
        else
        begin
            o_rsp_valid <= o_cmd.rd;
        end
    end

    // Old value is returned when a word both reads and writes
    always_ff @(posedge clk_pcie)
    begin
        if (o_cmd.rd)
        begin
            o_rsp.addr <= o_cmd.addr;
            o_rsp.data <= {i_rd_data[7:0], i_rd_data[15:8]};
        end
    end

    // Read-write space windows are known from reset on
    a_rw_read_known: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (o_cmd.rd && o_cmd.addr[15]) |-> !$isunknown(i_rd_data)
    );

endmodule

// ==== regs/pcie_cfg_regfile.sv ====
// Register file holding the read-write map and assembling the read-only map for host access
`timescale 1ns/10ps
`include "pcie_cfg_macros.svh"

module pcie_cfg_regfile
    import pcie_cfg_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,
    input  cfg_cmd_t      i_cmd,
    output logic [15:0]   o_rd_data,
    input  pcie_status_t  i_status,
    input  logic [1:0]    i_mgmt_live,      // {wr_en, rd_en} as seen by the core
    input  cfgrd_result_t i_result,
    input  logic          i_take_rd,
    input  logic          i_take_wr,
    input  logic          i_expire,
    output rw_ctrl_t      o_ctrl,
    output mgmt_req_t     o_mgmt_fields,
    output logic [31:0]   o_timer_limit
);

    localparam int MAP_BITS  = `PCIE_CFG_MAP_BYTES * 8;
    localparam int CTRL_BIT  = `PCIE_CFG_RW_CTRL * 8;
    localparam int DI_BIT    = `PCIE_CFG_RW_DI * 8;
    localparam int ADDR_BIT  = `PCIE_CFG_RW_ADDR * 8;
    localparam int TIMER_BIT = `PCIE_CFG_RW_TIMER * 8;

    logic [MAP_BITS-1:0]    rw_q;
    logic [MAP_BITS-1:0]    ro;
    logic [MAP_BITS+15:0]   rd_space;          // Zero pad so the last window ends in 0
    logic [6:0]             bit_off;
    logic                   in_range;
    logic                   wr_hit;
    logic [MAP_BITS-1:0]    wr_mask;
    logic [MAP_BITS-1:0]    wr_data;

    // ----------------------------------------
    // Read-only map
    // ----------------------------------------
    always_comb
    begin
        ro = '0;
        ro[15:0] = `PCIE_CFG_RO_MAGIC;
        ro[`PCIE_CFG_RO_SPECIAL*8 +: 2] = i_mgmt_live;
        ro[`PCIE_CFG_RO_ID*8 +: 16] = {i_status.func, i_status.device, i_status.bus};
        ro[`PCIE_CFG_RO_COMMAND*8 +: 16] = i_status.command;
        ro[`PCIE_CFG_RO_STATUS*8 +: 16] = i_status.status;
        ro[`PCIE_CFG_RO_RDINFO*8 +: 10] = i_result.addr;
        ro[`PCIE_CFG_RO_RDINFO*8 + 11] = i_result.valid;           // Bit 10 reserved
        ro[`PCIE_CFG_RO_RDINFO*8 + 12 +: 4] = i_result.byte_en;
        ro[`PCIE_CFG_RO_RDDATA*8 +: 32] = i_result.data;
    end

    // ----------------------------------------
    // Host window
    // ----------------------------------------
    assign bit_off  = {i_cmd.addr[3:0], 3'b000};
    assign in_range = i_cmd.addr[14:0] < 15'(`PCIE_CFG_MAP_BYTES);
    assign rd_space = {16'h0000, (i_cmd.addr[15] ? rw_q : ro)};
    assign o_rd_data = in_range ? rd_space[bit_off +: 16] : 16'h0000;

    assign wr_hit  = i_cmd.wr & i_cmd.addr[15] & in_range;
    assign wr_mask = MAP_BITS'(i_cmd.mask) << bit_off;     // Bits past the map fall off
    assign wr_data = MAP_BITS'(i_cmd.value) << bit_off;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw_q                       <= '0;
            rw_q[15:0]                 <= `PCIE_CFG_RW_MAGIC;
            rw_q[CTRL_BIT + 4]         <= 1'b1;                   // status_cl_en
            rw_q[CTRL_BIT + 5]         <= 1'b1;                   // command_en
            rw_q[ADDR_BIT + 12 +: 4]   <= 4'hf;                   // All bytes enabled
            rw_q[TIMER_BIT +: 32]      <= `PCIE_CFG_TIMER_DEFAULT;
        end
        else
        begin
            if (wr_hit)
            begin
                rw_q <= (rw_q & ~wr_mask) | (wr_data & wr_mask);
            end
            if (i_take_rd)
            begin
                rw_q[CTRL_BIT + 0] <= 1'b0;
            end
            if (i_take_wr)
            begin
                rw_q[CTRL_BIT + 1] <= 1'b0;
            end
            // Periodic status clear and command set, overrides a take of start_wr
            if (i_expire)
            begin
                rw_q[CTRL_BIT + 1]       <= 1'b1;
                rw_q[DI_BIT +: 32]       <= {`PCIE_CFG_AUTO_STATUS_DI, `PCIE_CFG_AUTO_CMD_DI};
                rw_q[ADDR_BIT +: 10]     <= `PCIE_CFG_AUTO_DWADDR;
                rw_q[ADDR_BIT + 10]      <= 1'b0;
                rw_q[ADDR_BIT + 11]      <= 1'b0;
                rw_q[ADDR_BIT + 12 +: 4] <= {rw_q[CTRL_BIT + 4], 1'b0,
                                             rw_q[CTRL_BIT + 5], rw_q[CTRL_BIT + 5]};
            end
        end
    end

    // ----------------------------------------
    // Field outputs
    // ----------------------------------------
    assign o_ctrl.start_rd     = rw_q[CTRL_BIT + 0];
    assign o_ctrl.start_wr     = rw_q[CTRL_BIT + 1];
    assign o_ctrl.status_cl_en = rw_q[CTRL_BIT + 4];
    assign o_ctrl.command_en   = rw_q[CTRL_BIT + 5];

    assign o_mgmt_fields.rd_en         = 1'b0;             // Driven by mgmt control
    assign o_mgmt_fields.wr_en         = 1'b0;
    assign o_mgmt_fields.di            = rw_q[DI_BIT +: 32];
    assign o_mgmt_fields.dwaddr        = rw_q[ADDR_BIT +: 10];
    assign o_mgmt_fields.wr_readonly   = rw_q[ADDR_BIT + 10];
    assign o_mgmt_fields.wr_rw1c_as_rw = rw_q[ADDR_BIT + 11];
    assign o_mgmt_fields.byte_en       = rw_q[ADDR_BIT + 12 +: 4];

    assign o_timer_limit = rw_q[TIMER_BIT +: 32];

endmodule

// ==== src/cfg_mgmt_ctrl.sv ====
// Config-management sequencer that starts single dword reads or writes and captures the result
`timescale 1ns/10ps

module cfg_mgmt_ctrl
    import pcie_cfg_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,
    input  cfg_cmd_t      i_cmd,           // Host activity holds the timer
    input  rw_ctrl_t      i_ctrl,
    input  mgmt_req_t     i_fields,
    input  mgmt_rsp_t     i_mgmt,
    output mgmt_req_t     o_mgmt,
    output logic          o_take_rd,
    output logic          o_take_wr,
    output logic          o_timer_en,
    output cfgrd_result_t o_result
);

    logic        rd_en_q;
    logic        wr_en_q;
    logic        busy;
    logic        done;
    logic        res_valid_q;
    logic [9:0]  res_addr_q;
    logic [3:0]  res_byte_en_q;
    logic [31:0] res_data_q;

    assign done = i_mgmt.rd_wr_done;
    assign busy = rd_en_q | wr_en_q;

    // Pending start waits until the current access ends
    assign o_take_rd = ~done & ~busy & i_ctrl.start_rd;
    assign o_take_wr = ~done & ~busy & ~i_ctrl.start_rd & i_ctrl.start_wr;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rd_en_q     <= 1'b0;
            wr_en_q     <= 1'b0;
            res_valid_q <= 1'b0;
        end
        else if (done)
        begin
            rd_en_q     <= 1'b0;
            wr_en_q     <= 1'b0;
            res_valid_q <= 1'b1;
        end
        else if (o_take_rd || o_take_wr)
        begin
            rd_en_q     <= o_take_rd;
            wr_en_q     <= o_take_wr;
            res_valid_q <= 1'b0;                       // New access hides the old result
        end
    end

    always_ff @(posedge clk_pcie)
    begin
        if (done)
        begin
            res_addr_q    <= i_fields.dwaddr;
            res_byte_en_q <= i_fields.byte_en;
            res_data_q    <= i_mgmt.do_data;
        end
    end

    always_comb
    begin
        o_mgmt       = i_fields;
        o_mgmt.rd_en = rd_en_q & ~done;                // Drop in the done cycle
        o_mgmt.wr_en = wr_en_q & ~done;
    end

    assign o_result = '{valid: res_valid_q, addr: res_addr_q,
                        byte_en: res_byte_en_q, data: res_data_q};

    assign o_timer_en = (i_ctrl.status_cl_en | i_ctrl.command_en) & ~i_cmd.rd & ~i_cmd.wr
                      & ~i_ctrl.start_rd & ~i_ctrl.start_wr & ~busy;

    a_one_access: assert property (
        @(posedge clk_pcie) disable iff (rst)
        !(rd_en_q && wr_en_q)
    );

endmodule

// ==== src/status_clear_timer.sv ====
// Idle-cycle counter that pulses expire once per programmed interval for status auto-clear
`timescale 1ns/10ps

module status_clear_timer
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_count_en,        // Idle and auto-clear enabled
    input  logic [31:0] i_limit,
    output logic        o_expire
);

    logic [31:0] count_q;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            count_q  <= '0;
            o_expire <= 1'b0;
        end
        else
        begin
            o_expire <= 1'b0;
            if (i_count_en && !o_expire)           // Hold one cycle after firing
            begin
                if (count_q < i_limit)
                begin
                    count_q <= count_q + 32'd1;
                end
                else
                begin
                    count_q  <= '0;
                    o_expire <= 1'b1;
                end
            end
        end
    end

    a_expire_pulse: assert property (
        @(posedge clk_pcie) disable iff (rst)
        o_expire |=> !o_expire
    );

endmodule

// ==== src/pcie_cfg_top.sv ====
// Top level of the PCIe config-control block, connects command port, regfile, mgmt control and timer
`timescale 1ns/10ps

module pcie_cfg_top
    import pcie_cfg_pkg::*;
(
    input  logic         clk_pcie,
    input  logic         rst,
    // Host command and response
    input  logic         i_cmd_valid,
    input  logic [63:0]  i_cmd_data,
    output logic         o_rsp_valid,
    output cfg_rsp_t     o_rsp,
    // PCIe core
    input  pcie_status_t i_status,
    input  mgmt_rsp_t    i_mgmt,
    output mgmt_req_t    o_mgmt
);

    cfg_cmd_t      cmd;
    logic [15:0]   rd_data;
    rw_ctrl_t      ctrl;
    mgmt_req_t     mgmt_fields;
    mgmt_req_t     mgmt_req;           // Gated requests, also fed back as live enables
    logic [31:0]   timer_limit;
    cfgrd_result_t result;
    logic          take_rd;
    logic          take_wr;
    logic          timer_en;
    logic          expire;

    assign o_mgmt = mgmt_req;

    cfg_cmd_port cfg_cmd_port_inst (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_data  (i_cmd_data),
        .o_cmd       (cmd),
        .i_rd_data   (rd_data),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp)
    );

    pcie_cfg_regfile pcie_cfg_regfile_inst (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .i_cmd         (cmd),
        .o_rd_data     (rd_data),
        .i_status      (i_status),
        .i_mgmt_live   ({mgmt_req.wr_en, mgmt_req.rd_en}),
        .i_result      (result),
        .i_take_rd     (take_rd),
        .i_take_wr     (take_wr),
        .i_expire      (expire),
        .o_ctrl        (ctrl),
        .o_mgmt_fields (mgmt_fields),
        .o_timer_limit (timer_limit)
    );

    cfg_mgmt_ctrl cfg_mgmt_ctrl_inst (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .i_cmd      (cmd),
        .i_ctrl     (ctrl),
        .i_fields   (mgmt_fields),
        .i_mgmt     (i_mgmt),
        .o_mgmt     (mgmt_req),
        .o_take_rd  (take_rd),
        .o_take_wr  (take_wr),
        .o_timer_en (timer_en),
        .o_result   (result)
    );

    status_clear_timer status_clear_timer_inst (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .i_count_en (timer_en),
        .i_limit    (timer_limit),
        .o_expire   (expire)
    );

endmodule

// ==== sim/tb_pcie_cfg.sv ====
// Directed testbench for the PCIe config-control block with a config-management core model
`timescale 1ns/10ps
`include "pcie_cfg_macros.svh"

module tb_pcie_cfg
    import pcie_cfg_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 4000;     // Five tests need well under 1000
    localparam int          AUTO_LIMIT     = 20;
    localparam int          AUTO_MARGIN    = 16;       // Expire, start bit and take latency
    localparam logic [15:0] RW_SPACE       = 16'h8000;

    logic         clk_pcie = 1'b0;
    logic         rst;
    logic         i_cmd_valid;
    logic [63:0]  i_cmd_data;
    logic         o_rsp_valid;
    cfg_rsp_t     o_rsp;
    pcie_status_t i_status;
    mgmt_rsp_t    i_mgmt = '0;
    mgmt_req_t    o_mgmt;

    int           cycle_count = 0;
    logic [31:0]  core_lfsr = 32'hf19;
    logic [31:0]  stim_lfsr;
    logic         core_active = 1'b0;
    logic         core_is_rd = 1'b0;
    logic [9:0]   core_dwaddr = '0;
    logic [2:0]   core_wait = '0;
    logic [31:0]  model_di;                        // Expected di register

    always #2 clk_pcie = ~clk_pcie;

    pcie_cfg_top pcie_cfg_top_inst (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_data  (i_cmd_data),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp),
        .i_status    (i_status),
        .i_mgmt      (i_mgmt),
        .o_mgmt      (o_mgmt)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [15:0] swap16(input logic [15:0] v);
        return {v[7:0], v[15:8]};
    endfunction

    // Core read data where every dwaddr bit shows up twice
    function automatic logic [31:0] core_word(input logic [9:0] dwaddr);
        return {~dwaddr, 6'h2b, dwaddr, 6'h14};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int count, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++)
        begin
            bits  = {bits[30:0], state[0]};
            state = galois_step(state);
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input cfg_rsp_t exp, input cfg_rsp_t act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("Fail o_rsp: expected %h got %h", exp, act));
        end
    endtask

    task automatic check_mgmt(input mgmt_req_t exp, input mgmt_req_t act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("Fail o_mgmt: expected %h got %h", exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("Fail %s: expected %h got %h", name, exp, act));
        end
    endtask

    // ----------------------------------------
    // Core model and watchdog
    // ----------------------------------------
    always @(negedge clk_pcie)
    begin
        logic [31:0] delay;
        if (i_mgmt.rd_wr_done)
        begin
            i_mgmt      <= '0;                     // Done lasts one cycle
            core_active <= 1'b0;
        end
        else if (core_active)
        begin
            if (core_wait == 3'd0)
            begin
                i_mgmt.rd_wr_done <= 1'b1;
                i_mgmt.do_data    <= core_is_rd ? core_word(core_dwaddr) : 32'h0;
            end
            else
            begin
                core_wait <= core_wait - 3'd1;
            end
        end
        else if (o_mgmt.rd_en || o_mgmt.wr_en)
        begin
            draw_bits(core_lfsr, 3, delay);        // Done after 1 to 8 cycles
            core_active <= 1'b1;
            core_is_rd  <= o_mgmt.rd_en;
            core_dwaddr <= o_mgmt.dwaddr;
            core_wait   <= delay[2:0];
        end
    end

    always @(posedge clk_pcie)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            stop_on_error("Simulation ran past the cycle limit without finishing the tests");
        end
    end

    // ----------------------------------------
    // Bus tasks that start and end on a falling edge
    // ----------------------------------------
    task automatic send_cmd(input logic rd, input logic wr, input logic [15:0] addr,
                            input logic [15:0] value, input logic [15:0] mask);
        i_cmd_valid = 1'b1;
        i_cmd_data  = {swap16(value), swap16(mask), addr, 2'b00, wr, rd, 12'h000};
        @(negedge clk_pcie);
        i_cmd_valid = 1'b0;
        i_cmd_data  = '0;
    endtask

    // Response data holds the register bytes in host order
    task automatic read_check(input logic [15:0] addr, input logic [15:0] exp_reg);
        cfg_rsp_t exp;
        exp.addr = addr;
        exp.data = swap16(exp_reg);
        send_cmd(1'b1, 1'b0, addr, 16'h0000, 16'h0000);
        check_bit("o_rsp_valid", 1'b1, o_rsp_valid);
        check_rsp(exp, o_rsp);
        @(negedge clk_pcie);
        check_bit("o_rsp_valid", 1'b0, o_rsp_valid);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] value,
                             input logic [15:0] mask);
        send_cmd(1'b0, 1'b1, addr, value, mask);
        check_bit("o_rsp_valid", 1'b0, o_rsp_valid);
    endtask

    task automatic wait_access_end();
        while (o_mgmt.rd_en || o_mgmt.wr_en || i_mgmt.rd_wr_done)
        begin
            @(negedge clk_pcie);
        end
    endtask

    task automatic wait_write_start(input int limit);
        int n;
        n = 0;
        while (!o_mgmt.wr_en)
        begin
            if (n > limit)
            begin
                stop_on_error("Auto-clear write did not start within the timer limit");
            end
            else
            begin
                n++;
                @(negedge clk_pcie);
            end
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        check_bit("o_mgmt.rd_en", 1'b0, o_mgmt.rd_en);
        check_bit("o_mgmt.wr_en", 1'b0, o_mgmt.wr_en);
        check_bit("o_rsp_valid", 1'b0, o_rsp_valid);
        read_check(RW_SPACE, `PCIE_CFG_RW_MAGIC);
        read_check(16'h0000, `PCIE_CFG_RO_MAGIC);
        read_check(16'(`PCIE_CFG_RO_ID), 16'hb13a);                 // Function 5 device 11 bus 3a
        read_check(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0030);     // Both enables set
        read_check(RW_SPACE + 16'(`PCIE_CFG_RW_ADDR), 16'hf000);
    endtask

    task automatic test_masked_writes();
        logic [31:0] bits;
        logic [15:0] value;
        logic [15:0] mask;
        logic [15:0] off;
        int          i;
        model_di = 32'h0;
        for (i = 0; i < 8; i++)
        begin
            draw_bits(stim_lfsr, 32, bits);
            value = bits[15:0];
            mask  = bits[31:16];
            draw_bits(stim_lfsr, 2, bits);
            off = (bits[1:0] == 2'd3) ? 16'd1 : {14'h0, bits[1:0]};   // Windows at +4, +5, +6
            write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_DI) + off, value, mask);
            model_di = (model_di & ~({16'h0, mask} << (off * 8)))
                     | ({16'h0, value & mask} << (off * 8));
            read_check(RW_SPACE + 16'(`PCIE_CFG_RW_DI), model_di[15:0]);
            read_check(RW_SPACE + 16'(`PCIE_CFG_RW_DI) + 16'd2, model_di[31:16]);
        end
        write_reg(16'(`PCIE_CFG_RO_COMMAND), 16'hffff, 16'hffff);
        read_check(16'(`PCIE_CFG_RO_COMMAND), i_status.command);
        read_check(RW_SPACE + 16'(`PCIE_CFG_RW_DI) + 16'd2, model_di[31:16]);
        read_check(RW_SPACE + 16'd16, 16'h0000);
        read_check(16'd17, 16'h0000);
        read_check(RW_SPACE + 16'h0040, 16'h0000);
    endtask

    task automatic test_config_read();
        logic [9:0]  dwaddr;
        logic [31:0] word;
        mgmt_req_t   exp;
        dwaddr = 10'h2c5;
        word   = core_word(dwaddr);
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_ADDR), {4'hf, 2'b00, dwaddr}, 16'hffff);
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0001, 16'h0001);
        @(negedge clk_pcie);                       // Start bit taken one edge later
        exp         = '0;
        exp.rd_en   = 1'b1;
        exp.di      = model_di;
        exp.dwaddr  = dwaddr;
        exp.byte_en = 4'hf;
        check_mgmt(exp, o_mgmt);
        wait_access_end();
        read_check(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0030);
        read_check(16'(`PCIE_CFG_RO_RDINFO), {4'hf, 1'b1, 1'b0, dwaddr});
        read_check(16'(`PCIE_CFG_RO_RDDATA), word[15:0]);
        read_check(16'(`PCIE_CFG_RO_RDDATA) + 16'd2, word[31:16]);
    endtask

    task automatic test_config_write();
        mgmt_req_t exp;
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_DI), 16'habcd, 16'hffff);
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_DI) + 16'd2, 16'h1234, 16'hffff);
        model_di = 32'h1234abcd;
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_ADDR), {4'h3, 1'b1, 1'b1, 10'h004}, 16'hffff);
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0002, 16'h0002);
        @(negedge clk_pcie);
        exp               = '0;
        exp.wr_en         = 1'b1;
        exp.di            = model_di;
        exp.dwaddr        = 10'h004;
        exp.byte_en       = 4'h3;
        exp.wr_readonly   = 1'b1;
        exp.wr_rw1c_as_rw = 1'b1;
        check_mgmt(exp, o_mgmt);
        read_check(16'(`PCIE_CFG_RO_SPECIAL), 16'h0002);              // Live wr_en
        wait_access_end();
        read_check(16'(`PCIE_CFG_RO_SPECIAL), 16'h0000);
        read_check(16'(`PCIE_CFG_RO_RDINFO), {4'h3, 1'b1, 1'b0, 10'h004});
    endtask

    task automatic test_auto_clear();
        mgmt_req_t exp;
        exp         = '0;
        exp.wr_en   = 1'b1;
        exp.di      = 32'hff000406;                // Status clear over command set
        exp.dwaddr  = 10'h001;
        exp.byte_en = 4'h8;                        // Status bytes only
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0000, 16'h0020);
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_TIMER), 16'(AUTO_LIMIT), 16'hffff);
        wait_write_start(AUTO_LIMIT + AUTO_MARGIN);
        check_mgmt(exp, o_mgmt);
        wait_access_end();
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0020, 16'h0020);
        wait_write_start(AUTO_LIMIT + AUTO_MARGIN);
        exp.byte_en = 4'hb;
        check_mgmt(exp, o_mgmt);
        wait_access_end();
        write_reg(RW_SPACE + 16'(`PCIE_CFG_RW_CTRL), 16'h0000, 16'h0030);
    endtask

    initial
    begin
        rst         = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_data  = '0;
        i_status    = '{bus: 8'h3a, device: 5'h11, func: 3'h5,
                        command: 16'h0547, status: 16'h0010};
        stim_lfsr   = 32'hf19;
        model_di    = 32'h0;
        repeat (2) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;

        test_reset_state();
        test_masked_writes();
        test_config_read();
        test_config_write();
        test_auto_clear();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/pcie_cfg_pkg.sv
src/cfg_cmd_port.sv
regs/pcie_cfg_regfile.sv
src/cfg_mgmt_ctrl.sv
src/status_clear_timer.sv
src/pcie_cfg_top.sv
sim/tb_pcie_cfg.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat flist.f)) common/pcie_cfg_macros.svh

obj_dir/Vtb_pcie_cfg: flist.f $(SRCS)
	verilator --binary --assert --timescale 1ns/10ps --top-module tb_pcie_cfg -f flist.f

run: obj_dir/Vtb_pcie_cfg
	obj_dir/Vtb_pcie_cfg

clean:
	rm -rf obj_dir

.PHONY: run clean
